// File: verilog/udp_tx_pkg.sv
package udp_tx_pkg;

    // ********************
    // field widths
    // ********************
    localparam int BYTE_W = 8;
    localparam int WORD_W = 32;
    localparam int LEN_W  = 16;
    localparam int MAC_W  = 48;

    localparam int HDR_WORDS     = 8;    // ip + udp + timestamp
    localparam int IP_HEAD_WORDS = 5;    // words covered by the ip checksum

    typedef logic [BYTE_W-1:0] byte_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [MAC_W-1:0]  mac_t;
    typedef word_t [HDR_WORDS-1:0] hdr_words_t;    // index 0 goes out first

    // ********************
    // frame constants
    // ********************
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hd5;
    localparam int    PREAMBLE_LEN  = 8;     // 7 x 0x55 then sfd
    localparam int    ETH_HEAD_LEN  = 14;

    localparam len_t  ETH_TYPE_IPV4  = 16'h0800;
    localparam len_t  IP_VER_IHL_TOS = 16'h4500;    // v4, 5 words, tos 0
    localparam len_t  IP_FLAGS_DF    = 16'h4000;    // don't fragment
    localparam byte_t IP_TTL         = 8'h40;
    localparam byte_t IP_PROTO_UDP   = 8'd17;

    // ********************
    // ports and lengths
    // ********************
    localparam len_t SRC_PORT      = 16'd1234;
    localparam len_t DEST_PORT_MIN = 16'd1234;
    localparam len_t DEST_PORT_MAX = 16'd1244;

    localparam len_t TIMESTAMP_LEN   = 16'd4;     // counted as payload
    localparam len_t IP_UDP_HEAD_LEN = 16'd28;
    localparam len_t UDP_HEAD_LEN    = 16'd8;

    // 46 byte minimum ip payload less headers and timestamp
    localparam len_t MIN_DATA_LEN = 16'd14;
    localparam int   FCS_LEN      = 4;

    // ********************
    // crc-32
    // ********************
    localparam word_t CRC_POLY = 32'h04c1_1db7;    // normal form, reflected in use
    localparam word_t CRC_INIT = 32'hffff_ffff;

endpackage

// File: verilog/ip_checksum.sv
`timescale 1ns/10ps

module ip_checksum (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   cksum_start,
    input  udp_tx_pkg::hdr_words_t hdr_in,
    output logic                   cksum_done,
    output udp_tx_pkg::len_t       cksum_value
);
    import udp_tx_pkg::*;

    logic [1:0] step;       // 0 idle, 1-2 carry folds, 3 result
    word_t      acc;
    word_t      hdr_sum;

    // ten 16 bit halves of the ip header
    always_comb begin
        hdr_sum = '0;
        for (int i = 0; i < IP_HEAD_WORDS; i++) begin
            hdr_sum = hdr_sum + hdr_in[i][31:16] + hdr_in[i][15:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step       <= 2'd0;
            cksum_done <= 1'b0;
        end else begin
            cksum_done <= 1'b0;
            if (cksum_start) begin
                step <= 2'd1;
            end else if (step != 2'd0) begin
                step <= step + 2'd1;      // wraps back to idle after 3
                if (step == 2'd3)
                    cksum_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cksum_start)
            acc <= hdr_sum;
        else if (step == 2'd1 || step == 2'd2)
            acc <= {16'h0, acc[31:16]} + {16'h0, acc[15:0]};    // end-around carry
        if (step == 2'd3)
            cksum_value <= ~acc[15:0];
    end

endmodule

// File: verilog/udp_header_gen.sv
`timescale 1ns/10ps

module udp_header_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   tx_start_en,
    input  udp_tx_pkg::len_t       tx_byte_num,
    input  udp_tx_pkg::word_t      board_ip,
    input  udp_tx_pkg::word_t      des_ip,
    input  logic                   timestamp_rst,
    input  logic                   frame_done,
    output logic                   hdr_valid,
    output udp_tx_pkg::hdr_words_t hdr_words,
    output udp_tx_pkg::len_t       payload_len
);
    import udp_tx_pkg::*;

    logic  start_d0;
    logic  start_d1;
    logic  pos_start;
    logic  accept;
    logic  busy;          // one frame in flight
    logic  cksum_start;
    logic  cksum_done;
    len_t  cksum_value;
    len_t  ip_id;
    len_t  des_port;
    word_t timestamp;     // frames sent since timestamp_rst
    len_t  total_len;
    len_t  udp_len;

    assign pos_start = start_d0 & ~start_d1;
    assign accept    = pos_start & ~busy;      // starts during a frame are dropped

    assign total_len = tx_byte_num + TIMESTAMP_LEN + IP_UDP_HEAD_LEN;
    assign udp_len   = tx_byte_num + TIMESTAMP_LEN + UDP_HEAD_LEN;

    // ********************
    // control
    // ********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_d0    <= 1'b0;
            start_d1    <= 1'b0;
            busy        <= 1'b0;
            cksum_start <= 1'b0;
            hdr_valid   <= 1'b0;
            ip_id       <= '0;
            des_port    <= DEST_PORT_MIN;
        end else begin
            start_d0    <= tx_start_en;
            start_d1    <= start_d0;
            cksum_start <= accept;
            hdr_valid   <= cksum_done;     // header complete, hand to sequencer
            if (accept) begin
                busy     <= 1'b1;
                ip_id    <= ip_id + 16'd1;
                des_port <= (des_port < DEST_PORT_MAX) ? des_port + 16'd1 : DEST_PORT_MIN;
            end else if (frame_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            timestamp <= '0;
        else if (timestamp_rst)
            timestamp <= '0;
        else if (frame_done)
            timestamp <= timestamp + 32'd1;
    end

    // ********************
    // header words
    // ********************
    always_ff @(posedge clk) begin
        if (accept) begin
            payload_len  <= tx_byte_num;
            hdr_words[0] <= {IP_VER_IHL_TOS, total_len};
            hdr_words[1] <= {ip_id + 16'd1, IP_FLAGS_DF};
            hdr_words[2] <= {IP_TTL, IP_PROTO_UDP, 16'h0000};   // checksum filled later
            hdr_words[3] <= board_ip;
            hdr_words[4] <= des_ip;
            hdr_words[5] <= {SRC_PORT, des_port};
            hdr_words[6] <= {udp_len, 16'h0000};                // no udp checksum
            hdr_words[7] <= timestamp;
        end else if (cksum_done) begin
            hdr_words[2][15:0] <= cksum_value;
        end
    end

    ip_checksum u_ip_checksum (
        .clk         (clk),
        .rst_n       (rst_n),
        .cksum_start (cksum_start),
        .hdr_in      (hdr_words),
        .cksum_done  (cksum_done),
        .cksum_value (cksum_value)
    );

endmodule

// File: verilog/crc32_d8.sv
`timescale 1ns/10ps

module crc32_d8 (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              crc_en,
    input  logic              crc_clr,
    input  udp_tx_pkg::byte_t data_in,
    output udp_tx_pkg::word_t crc_state,
    output udp_tx_pkg::word_t crc_next
);
    import udp_tx_pkg::*;

    // lsb-first update over one byte
    function automatic word_t crc_update(input word_t crc, input byte_t data);
        word_t poly_rev;
        word_t c;
        for (int i = 0; i < 32; i++) begin
            poly_rev[i] = CRC_POLY[31-i];
        end
        c = crc ^ {24'h0, data};
        for (int b = 0; b < 8; b++) begin
            if (c[0])
                c = (c >> 1) ^ poly_rev;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    // includes the byte on the wire this cycle
    assign crc_next = crc_update(crc_state, data_in);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            crc_state <= CRC_INIT;
        else if (crc_clr)
            crc_state <= CRC_INIT;     // ready for the next frame
        else if (crc_en)
            crc_state <= crc_next;
    end

endmodule

// File: verilog/gmii_frame_seq.sv
`timescale 1ns/10ps

module gmii_frame_seq (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hdr_valid,
    input  udp_tx_pkg::hdr_words_t hdr_words,
    input  udp_tx_pkg::len_t       payload_len,
    input  udp_tx_pkg::mac_t       des_mac,
    input  udp_tx_pkg::mac_t       board_mac,
    input  udp_tx_pkg::word_t      tx_data,
    input  udp_tx_pkg::word_t      crc_state,
    input  udp_tx_pkg::word_t      crc_next,
    output logic                   tx_req,
    output logic                   gmii_tx_en,
    output udp_tx_pkg::byte_t      gmii_txd,
    output logic                   crc_en,
    output logic                   crc_clr,
    output logic                   frame_done,
    output logic                   tx_done
);
    import udp_tx_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_eth_head,
        st_ip_head,
        st_payload,
        st_fcs
    } state_t;

    state_t                    state;
    len_t                      byte_cnt;
    logic [2:0]                word_idx;
    logic [1:0]                lane;        // byte within a 32 bit word, msb first
    word_t                     data_word;   // payload word being serialized
    len_t                      data_len;
    logic [ETH_HEAD_LEN*8-1:0] eth_head;
    logic                      pay_live;
    byte_t                     eth_byte;
    byte_t                     ip_byte;
    byte_t                     pay_byte;
    byte_t                     fcs_byte;

    assign data_len = (payload_len > MIN_DATA_LEN) ? payload_len : MIN_DATA_LEN;
    assign eth_head = {des_mac, board_mac, ETH_TYPE_IPV4};
    assign eth_byte = eth_head[8*(ETH_HEAD_LEN-1-byte_cnt[3:0]) +: 8];
    assign ip_byte  = hdr_words[word_idx][8*(3-lane) +: 8];

    // past payload_len only zero padding goes out
    assign pay_live = (byte_cnt < payload_len);
    assign pay_byte = !pay_live     ? 8'h00 :
                      (lane == 2'd0) ? tx_data[31:24] : data_word[8*(3-lane) +: 8];

    // first fcs byte still needs the last padding byte folded in
    assign fcs_byte = (byte_cnt[1:0] == 2'd0) ? ~crc_next[7:0]
                                              : ~crc_state[8*byte_cnt[1:0] +: 8];

    always_ff @(posedge clk) begin
        if (state == st_payload && lane == 2'd0 && pay_live)
            data_word <= tx_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            byte_cnt   <= '0;
            word_idx   <= '0;
            lane       <= '0;
            tx_req     <= 1'b0;
            gmii_tx_en <= 1'b0;
            gmii_txd   <= '0;
            crc_en     <= 1'b0;
            crc_clr    <= 1'b0;
            frame_done <= 1'b0;
            tx_done    <= 1'b0;
        end else begin
            tx_req     <= 1'b0;
            crc_en     <= 1'b0;
            crc_clr    <= 1'b0;
            frame_done <= 1'b0;
            tx_done    <= 1'b0;
            case (state)
                st_idle: begin
                    gmii_tx_en <= 1'b0;
                    gmii_txd   <= '0;
                    if (hdr_valid) begin
                        gmii_tx_en <= 1'b1;
                        gmii_txd   <= PREAMBLE_BYTE;
                        byte_cnt   <= 16'd1;
                        state      <= st_preamble;
                    end
                end
                st_preamble: begin
                    gmii_tx_en <= 1'b1;
                    if (byte_cnt == PREAMBLE_LEN - 1) begin
                        gmii_txd <= SFD_BYTE;
                        byte_cnt <= '0;
                        state    <= st_eth_head;
                    end else begin
                        gmii_txd <= PREAMBLE_BYTE;
                        byte_cnt <= byte_cnt + 16'd1;
                    end
                end
                st_eth_head: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    gmii_txd   <= eth_byte;
                    if (byte_cnt == ETH_HEAD_LEN - 1) begin
                        byte_cnt <= '0;
                        word_idx <= '0;
                        lane     <= '0;
                        state    <= st_ip_head;
                    end else begin
                        byte_cnt <= byte_cnt + 16'd1;
                    end
                end
                st_ip_head: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    gmii_txd   <= ip_byte;
                    lane       <= lane + 2'd1;
                    if (lane == 2'd2 && word_idx == HDR_WORDS - 1)
                        tx_req <= 1'b1;                 // first payload word
                    if (lane == 2'd3) begin
                        if (word_idx == HDR_WORDS - 1)
                            state <= st_payload;
                        else
                            word_idx <= word_idx + 3'd1;
                    end
                end
                st_payload: begin
                    gmii_tx_en <= 1'b1;
                    crc_en     <= 1'b1;
                    gmii_txd   <= pay_byte;
                    lane       <= lane + 2'd1;
                    if (lane == 2'd2 && byte_cnt + 16'd2 < payload_len)
                        tx_req <= 1'b1;                 // another word follows
                    if (byte_cnt == data_len - 16'd1) begin
                        byte_cnt <= '0;
                        lane     <= '0;
                        state    <= st_fcs;
                    end else begin
                        byte_cnt <= byte_cnt + 16'd1;
                    end
                end
                st_fcs: begin
                    if (byte_cnt == FCS_LEN) begin
                        gmii_tx_en <= 1'b0;
                        gmii_txd   <= '0;
                        crc_clr    <= 1'b1;
                        frame_done <= 1'b1;
                        tx_done    <= 1'b1;
                        byte_cnt   <= '0;
                        state      <= st_idle;
                    end else begin
                        gmii_tx_en <= 1'b1;
                        gmii_txd   <= fcs_byte;    // low byte first
                        byte_cnt   <= byte_cnt + 16'd1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: verilog/udp_tx.sv
`timescale 1ns/10ps

module udp_tx (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tx_start_en,
    input  udp_tx_pkg::len_t  tx_byte_num,
    input  udp_tx_pkg::word_t tx_data,
    input  udp_tx_pkg::mac_t  des_mac,
    input  udp_tx_pkg::mac_t  board_mac,
    input  udp_tx_pkg::word_t des_ip,
    input  udp_tx_pkg::word_t board_ip,
    input  logic              timestamp_rst,
    output logic              tx_req,
    output logic              gmii_tx_en,
    output udp_tx_pkg::byte_t gmii_txd,
    output logic              tx_done
);
    import udp_tx_pkg::*;

    logic       hdr_valid;
    hdr_words_t hdr_words;
    len_t       payload_len;
    logic       frame_done;
    logic       crc_en;
    logic       crc_clr;
    word_t      crc_state;
    word_t      crc_next;

    // ********************
    // header, checksum, counters
    // ********************
    udp_header_gen u_hdr_gen (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_start_en   (tx_start_en),
        .tx_byte_num   (tx_byte_num),
        .board_ip      (board_ip),
        .des_ip        (des_ip),
        .timestamp_rst (timestamp_rst),
        .frame_done    (frame_done),
        .hdr_valid     (hdr_valid),
        .hdr_words     (hdr_words),
        .payload_len   (payload_len)
    );

    // fcs runs over the byte on the gmii bus
    crc32_d8 u_crc (
        .clk       (clk),
        .rst_n     (rst_n),
        .crc_en    (crc_en),
        .crc_clr   (crc_clr),
        .data_in   (gmii_txd),
        .crc_state (crc_state),
        .crc_next  (crc_next)
    );

    gmii_frame_seq u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .hdr_valid   (hdr_valid),
        .hdr_words   (hdr_words),
        .payload_len (payload_len),
        .des_mac     (des_mac),
        .board_mac   (board_mac),
        .tx_data     (tx_data),
        .crc_state   (crc_state),
        .crc_next    (crc_next),
        .tx_req      (tx_req),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd),
        .crc_en      (crc_en),
        .crc_clr     (crc_clr),
        .frame_done  (frame_done),
        .tx_done     (tx_done)
    );

endmodule

// File: tb/udp_tx_sva.sv
`timescale 1ns/10ps

module udp_tx_sva (
    input logic clk,
    input logic rst_n,
    input logic gmii_tx_en,
    input logic tx_req,
    input logic tx_done
);

    int err_cnt = 0;    // failed assertions so far

    // done lasts one cycle
    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done |=> !tx_done)
        else begin
            $error("tx_done held for more than one cycle");
            err_cnt++;
        end

    done_after_frame: assert property (@(posedge clk) disable iff (!rst_n)
        tx_done |-> $fell(gmii_tx_en))    // frame just ended
        else begin
            $error("tx_done without a falling edge of gmii_tx_en");
            err_cnt++;
        end

    req_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        tx_req |-> gmii_tx_en)
        else begin
            $error("tx_req raised outside a frame");
            err_cnt++;
        end

    // frame ends only together with done
    no_early_drop: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(gmii_tx_en) |-> tx_done)
        else begin
            $error("gmii_tx_en dropped before the end of the frame");
            err_cnt++;
        end

endmodule

bind udp_tx udp_tx_sva u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .gmii_tx_en (gmii_tx_en),
    .tx_req     (tx_req),
    .tx_done    (tx_done)
);

// File: tb/udp_tx_tb.sv
`timescale 1ns/10ps

module udp_tx_tb;
    import udp_tx_pkg::*;

    localparam int    NUM_FRAMES   = 19;
    localparam int    FRAME_BUDGET = 300;    // longest frame needs about 135 cycles
    localparam int    CYCLE_LIMIT  = NUM_FRAMES * FRAME_BUDGET;
    localparam int    OFF_IP       = 22;     // byte offsets from the first preamble byte
    localparam int    OFF_UDP      = 42;
    localparam int    OFF_TS       = 50;
    localparam int    OFF_DATA     = 54;
    localparam mac_t  DES_MAC      = 48'h00_1b_21_a4_7c_10;
    localparam mac_t  BOARD_MAC    = 48'h02_00_5e_10_00_01;
    localparam word_t DES_IP       = 32'hc0a8_0102;
    localparam word_t BOARD_IP     = 32'hc0a8_010a;

    logic  clk;
    logic  rst_n;
    logic  tx_start_en;
    len_t  tx_byte_num;
    word_t tx_data;
    logic  timestamp_rst;
    logic  tx_req;
    logic  gmii_tx_en;
    byte_t gmii_txd;
    logic  tx_done;

    integer seed = 32'h68d5dd30;
    int     cycle_cnt = 0;
    int     req_cnt = 0;
    int     frames_sent = 0;
    int     ts_base = 0;       // frames_sent at the last timestamp_rst
    byte_t  cap[$];
    byte_t  exp_q[$];
    word_t  pay_q[$];

    udp_tx dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_start_en   (tx_start_en),
        .tx_byte_num   (tx_byte_num),
        .tx_data       (tx_data),
        .des_mac       (DES_MAC),
        .board_mac     (BOARD_MAC),
        .des_ip        (DES_IP),
        .board_ip      (BOARD_IP),
        .timestamp_rst (timestamp_rst),
        .tx_req        (tx_req),
        .gmii_tx_en    (gmii_tx_en),
        .gmii_txd      (gmii_txd),
        .tx_done       (tx_done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT)
            abort_run($sformatf("timeout: run exceeded %0d cycles", CYCLE_LIMIT));
    end

    // ********************
    // payload model, capture
    // ********************
    always @(negedge clk) begin
        if (gmii_tx_en)
            cap.push_back(gmii_txd);
        if (tx_req) begin
            tx_data = $random(seed);     // valid from the next rising edge
            pay_q.push_back(tx_data);
            req_cnt = req_cnt + 1;
        end
        if (dut0.u_sva.err_cnt != 0)
            abort_run("an assertion on the DUT outputs failed");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] expv);
        assert (got === expv) else begin
            abort_run($sformatf("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h",
                                $time, name, got, expv));
        end
    endtask

    // reflected crc-32, one bit at a time
    function automatic word_t crc_byte(input word_t crc, input byte_t b);
        word_t c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            c = (c[0] ^ b[i]) ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
        end
        return c;
    endfunction

    // ones' complement sum of ten 16 bit words
    function automatic len_t fold_sum(input byte_t h[20]);
        logic [31:0] s;
        s = '0;
        for (int i = 0; i < 10; i++) begin
            s = s + {h[2*i], h[2*i+1]};
        end
        s = s[31:16] + s[15:0];
        s = s[31:16] + s[15:0];    // second fold catches the last carry
        return s[15:0];
    endfunction

    function automatic len_t cap16(input int off);
        return {cap[off], cap[off+1]};
    endfunction

    // ********************
    // reference frame
    // ********************
    task automatic build_expected(input int n);
        logic [159:0] ip;
        logic [95:0]  udp_ts;
        byte_t        h[20];
        len_t         ck;
        word_t        w;
        word_t        crc;
        int           span;
        span   = (n > 14) ? n : 14;
        ip     = {16'h4500, 16'(n + 32), 16'(frames_sent + 1), 16'h4000, 8'h40, 8'd17,
                  16'h0000, BOARD_IP, DES_IP};
        udp_ts = {16'd1234, 16'(1234 + frames_sent % 11), 16'(n + 12), 16'h0000,
                  32'(frames_sent - ts_base)};
        for (int i = 0; i < 20; i++) begin
            h[i] = ip[8*(19-i) +: 8];
        end
        ck    = ~fold_sum(h);
        h[10] = ck[15:8];
        h[11] = ck[7:0];
        exp_q.delete();
        for (int i = 0; i < 7; i++)
            exp_q.push_back(8'h55);
        exp_q.push_back(8'hd5);
        for (int i = 5; i >= 0; i--)
            exp_q.push_back(DES_MAC[8*i +: 8]);
        for (int i = 5; i >= 0; i--)
            exp_q.push_back(BOARD_MAC[8*i +: 8]);
        exp_q.push_back(8'h08);
        exp_q.push_back(8'h00);
        for (int i = 0; i < 20; i++)
            exp_q.push_back(h[i]);
        for (int i = 11; i >= 0; i--)
            exp_q.push_back(udp_ts[8*i +: 8]);
        for (int i = 0; i < span; i++) begin
            w = (i < n) ? pay_q[i/4] : 32'h0;    // zero padding past n
            exp_q.push_back(w[8*(3 - i%4) +: 8]);
        end
        crc = 32'hffff_ffff;
        for (int i = 8; i < exp_q.size(); i++)
            crc = crc_byte(crc, exp_q[i]);
        crc = ~crc;
        for (int i = 0; i < 4; i++)
            exp_q.push_back(crc[8*i +: 8]);    // fcs low byte first
    endtask

    task automatic verify_ip_sum();
        byte_t h[20];
        for (int i = 0; i < 20; i++)
            h[i] = cap[OFF_IP + i];
        expect_equal("ip header ones' sum", fold_sum(h), 16'hffff);
    endtask

    task automatic compare_fcs();
        word_t crc;
        int    last;
        last = cap.size() - 4;
        crc  = 32'hffff_ffff;
        for (int i = 8; i < last; i++)
            crc = crc_byte(crc, cap[i]);
        expect_equal("fcs", {cap[last+3], cap[last+2], cap[last+1], cap[last]}, ~crc);
    endtask

    task automatic send_frame(input int n);
        cap.delete();
        pay_q.delete();
        req_cnt = 0;
        @(negedge clk);
        tx_byte_num = len_t'(n);
        tx_start_en = 1'b1;
        @(negedge clk);
        tx_start_en = 1'b0;
        while (tx_done !== 1'b1)
            @(negedge clk);
        expect_equal("tx_req count", req_cnt, n / 4);
        expect_equal("frame length", cap.size(), 8 + 14 + 32 + ((n > 14) ? n : 14) + 4);
        build_expected(n);
        for (int i = 0; i < exp_q.size(); i++)
            expect_equal($sformatf("gmii_txd byte %0d", i), cap[i], exp_q[i]);
        verify_ip_sum();
        compare_fcs();
        frames_sent = frames_sent + 1;
    endtask

    // ********************
    // directed tests
    // ********************
    task automatic test_basic_frame();
        send_frame(32);
        expect_equal("sfd", cap[7], 8'hd5);
        expect_equal("ethertype", cap16(20), 16'h0800);
        expect_equal("ip total length", cap16(OFF_IP + 2), 64);
        expect_equal("ip id", cap16(OFF_IP + 4), 1);
        expect_equal("udp src port", cap16(OFF_UDP), 1234);
        expect_equal("udp dest port", cap16(OFF_UDP + 2), 1234);
        expect_equal("udp length", cap16(OFF_UDP + 4), 44);
        expect_equal("timestamp", {cap16(OFF_TS), cap16(OFF_TS + 2)}, 0);
    endtask

    task automatic test_ip_checksum();
        send_frame(8);     // each frame is summed inside send_frame
        send_frame(48);
    endtask

    task automatic test_fcs();
        send_frame(12);    // two pad bytes in the crc
        send_frame(64);
    endtask

    task automatic test_short_padding();
        send_frame(4);
        expect_equal("ip total length", cap16(OFF_IP + 2), 36);
        expect_equal("udp length", cap16(OFF_UDP + 4), 16);
        expect_equal("payload word", {cap16(OFF_DATA), cap16(OFF_DATA + 2)}, pay_q[0]);
        for (int i = 4; i < 14; i++)
            expect_equal($sformatf("pad byte %0d", i), cap[OFF_DATA + i], 8'h00);
    endtask

    task automatic test_rotation_and_timestamp();
        len_t port;
        len_t prev_port;
        len_t prev_id;
        bit   wrapped;
        wrapped   = 1'b0;
        prev_port = '0;
        prev_id   = '0;
        for (int f = 0; f < 12; f++) begin
            send_frame(16);
            port = cap16(OFF_UDP + 2);
            if (f > 0) begin
                expect_equal("ip id step", cap16(OFF_IP + 4), prev_id + 16'd1);
                expect_equal("udp dest port", port,
                             (prev_port == 16'd1244) ? 16'd1234 : prev_port + 16'd1);
                if (prev_port == 16'd1244)
                    wrapped = 1'b1;
            end
            expect_equal("timestamp", {cap16(OFF_TS), cap16(OFF_TS + 2)},
                         frames_sent - 1 - ts_base);
            prev_port = port;
            prev_id   = cap16(OFF_IP + 4);
        end
        expect_equal("dest port wrap seen", wrapped, 1'b1);
        @(negedge clk);
        timestamp_rst = 1'b1;
        @(negedge clk);
        timestamp_rst = 1'b0;
        ts_base = frames_sent;
        send_frame(16);
        expect_equal("timestamp after reset", {cap16(OFF_TS), cap16(OFF_TS + 2)}, 0);
    endtask

    initial begin
        rst_n         = 1'b0;
        tx_start_en   = 1'b0;
        tx_byte_num   = '0;
        tx_data       = '0;
        timestamp_rst = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        expect_equal("gmii_tx_en", gmii_tx_en, 1'b0);
        expect_equal("tx_req", tx_req, 1'b0);
        expect_equal("tx_done", tx_done, 1'b0);
        expect_equal("gmii_txd", gmii_txd, 8'h00);
        test_basic_frame();
        test_ip_checksum();
        test_fcs();
        test_short_padding();
        test_rotation_and_timestamp();
        repeat (2) @(negedge clk);    // last done pulse still under assertion
        if (dut0.u_sva.err_cnt != 0) begin
            abort_run("an assertion on the DUT outputs failed");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

// File: udp_tx.f
verilog/udp_tx_pkg.sv
verilog/ip_checksum.sv
verilog/udp_header_gen.sv
verilog/crc32_d8.sv
verilog/gmii_frame_seq.sv
verilog/udp_tx.sv
tb/udp_tx_sva.sv
tb/udp_tx_tb.sv
